// ==== logic/ahb_decoder.sv ====
// Single AHB-Lite master assumed and unmapped space reads zero with writes dropped
`default_nettype none

module ahb_decoder
(
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire periph_pkg::ahb_m2s_t i_bus,
    output periph_pkg::ahb_s2m_t      o_bus,
    output periph_pkg::slv_access_t   o_gpio_acc,
    output periph_pkg::slv_access_t   o_uart_acc,
    input  wire periph_pkg::hdata_t   i_gpio_rdata,
    input  wire periph_pkg::hdata_t   i_uart_rdata,
    input  wire logic                 i_uart_ready
);
    import periph_pkg::*;

    logic     addr_valid;  // Address phase accepted this edge
    logic     hit_gpio;
    logic     hit_uart;
    hstrb_t   strb_a;      // Lanes of the address phase
    logic     dp_gpio;     // Data phase owners
    logic     dp_uart;
    logic     dp_write;
    reg_ofs_t dp_ofs;
    hstrb_t   dp_strb;

    // ------------------------------
    // Address phase
    // ------------------------------
    assign addr_valid = o_bus.hready &&
                        (i_bus.htrans == HTRANS_NONSEQ || i_bus.htrans == HTRANS_SEQ);
    assign hit_gpio = i_bus.haddr[31:SLAVE_WINDOW_BITS] == GPIO_BASE[31:SLAVE_WINDOW_BITS];
    assign hit_uart = i_bus.haddr[31:SLAVE_WINDOW_BITS] == UART_BASE[31:SLAVE_WINDOW_BITS];

    // Byte strobes from size and low address
    always_comb
    begin
        case (i_bus.hsize)
            HSIZE_BYTE: strb_a = hstrb_t'(4'b0001 << i_bus.haddr[1:0]);
            HSIZE_HALF: strb_a = i_bus.haddr[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: strb_a = 4'b1111;
            default:    strb_a = 4'b0000; // Wider than the bus
        endcase
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            dp_gpio  <= 1'b0;
            dp_uart  <= 1'b0;
            dp_write <= 1'b0;
        end
        else if (o_bus.hready)  // Held through a stall
        begin
            dp_gpio  <= addr_valid && hit_gpio;
            dp_uart  <= addr_valid && hit_uart;
            dp_write <= i_bus.hwrite;
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_bus.hready)
        begin
            dp_ofs  <= i_bus.haddr[SLAVE_WINDOW_BITS-1:2];
            dp_strb <= strb_a;
        end
    end

    // ------------------------------
    // Data phase
    // ------------------------------
    assign o_gpio_acc = '{wr:    dp_gpio && dp_write,
                          rd:    dp_gpio && !dp_write,
                          ofs:   dp_ofs,
                          wstrb: dp_strb,
                          wdata: i_bus.hwdata};

    assign o_uart_acc = '{wr:    dp_uart && dp_write,
                          rd:    dp_uart && !dp_write,
                          ofs:   dp_ofs,
                          wstrb: dp_strb,
                          wdata: i_bus.hwdata};

    always_comb
    begin
        o_bus.hresp  = 1'b0;                          // Always OKAY
        o_bus.hready = dp_uart ? i_uart_ready : 1'b1; // Only the UART stalls
        if (dp_gpio)
            o_bus.hrdata = i_gpio_rdata;
        else if (dp_uart)
            o_bus.hrdata = i_uart_rdata;
        else
            o_bus.hrdata = '0;                        // Unmapped or idle
    end

endmodule

`default_nettype wire

// ==== logic/ahb_gpio.sv ====
// GPIO_WIDTH from 1 to 32 with pins above it reading zero and no tristate pad here
`default_nettype none

module ahb_gpio
#(
    parameter int GPIO_WIDTH = 32
)
(
    input  wire logic                    clk,
    input  wire logic                    RSTn,
    input  wire periph_pkg::slv_access_t i_acc,
    output periph_pkg::hdata_t           o_rdata,
    input  wire logic [GPIO_WIDTH-1:0]   i_gpio_in,
    output logic [GPIO_WIDTH-1:0]        o_gpio_out,
    output logic [GPIO_WIDTH-1:0]        o_gpio_oe
);
    import periph_pkg::*;

    typedef logic [GPIO_WIDTH-1:0] pins_t;

    pins_t out_q;    // Output data
    pins_t oe_q;     // Output enable
    pins_t in_s1;    // Synchroniser stage 1
    pins_t in_s2;    // Stage 2 seen by reads

    // Keep old bits where the lane strobe is clear
    function automatic pins_t merge_lanes(input pins_t old_q, input hdata_t wdata,
                                          input hstrb_t strb);
        pins_t res;
        res = old_q;
        for (int i = 0; i < GPIO_WIDTH; i++)
        begin
            if (strb[i/8])
                res[i] = wdata[i];
        end
        return res;
    endfunction

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            out_q <= '0;
            oe_q  <= '0;
            in_s1 <= '0;
            in_s2 <= '0;
        end
        else
        begin
            in_s1 <= i_gpio_in;  // Pins are asynchronous
            in_s2 <= in_s1;
            if (i_acc.wr && i_acc.ofs == GPIO_OUT_OFS)
                out_q <= merge_lanes(out_q, i_acc.wdata, i_acc.wstrb);
            if (i_acc.wr && i_acc.ofs == GPIO_OE_OFS)
                oe_q <= merge_lanes(oe_q, i_acc.wdata, i_acc.wstrb);
            // IN offset is read only
        end
    end

    assign o_gpio_out = out_q;
    assign o_gpio_oe  = oe_q;

    // Zero-extended read mux
    always_comb
    begin
        o_rdata = '0;
        if (i_acc.rd)
        begin
            case (i_acc.ofs)
                GPIO_OUT_OFS: o_rdata = hdata_t'(out_q);
                GPIO_OE_OFS:  o_rdata = hdata_t'(oe_q);
                GPIO_IN_OFS:  o_rdata = hdata_t'(in_s2);
                default:      o_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ahb_uart.sv ====
// One-byte receive holding register that is overwritten when not read in time
`default_nettype none

module ahb_uart
(
    input  wire logic                    clk,
    input  wire logic                    RSTn,
    input  wire periph_pkg::slv_access_t i_acc,
    output periph_pkg::hdata_t           o_rdata,
    output logic                         o_ready,
    output logic                         o_tx_start,
    output periph_pkg::uart_byte_t       o_tx_byte,
    input  wire logic                    i_tx_busy,
    input  wire logic                    i_rx_strobe,
    input  wire periph_pkg::uart_byte_t  i_rx_byte,
    output logic                         o_irq
);
    import periph_pkg::*;

    logic       tx_wr;       // DATA write carrying lane 0
    logic       data_rd;     // DATA read, pops the byte
    logic       rx_valid_q;
    uart_byte_t rx_data_q;

    assign tx_wr   = i_acc.wr && i_acc.ofs == UART_DATA_OFS && i_acc.wstrb[0];
    assign data_rd = i_acc.rd && i_acc.ofs == UART_DATA_OFS;

    // ------------------------------
    // Transmit side
    // ------------------------------
    assign o_tx_start = tx_wr && !i_tx_busy;
    assign o_tx_byte  = i_acc.wdata[7:0];
    assign o_ready    = !(tx_wr && i_tx_busy);  // Stall until the engine is idle

    // ------------------------------
    // Receive side
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            rx_valid_q <= 1'b0;
        else if (i_rx_strobe)
            rx_valid_q <= 1'b1;   // New byte wins over a read
        else if (data_rd)
            rx_valid_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (i_rx_strobe)
            rx_data_q <= i_rx_byte;
    end

    assign o_irq = rx_valid_q;

    always_comb
    begin
        o_rdata = '0;
        if (i_acc.rd)
        begin
            case (i_acc.ofs)
                UART_DATA_OFS: o_rdata = hdata_t'(rx_data_q);
                UART_STAT_OFS:
                begin
                    o_rdata[STAT_TX_BUSY_BIT]  = i_tx_busy;
                    o_rdata[STAT_RX_VALID_BIT] = rx_valid_q;
                end
                default: o_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/periph_pkg.sv ====
// Fixed 32-bit AHB-Lite data path and a 16-byte window per slave with no error response
`default_nettype none

package periph_pkg;

    // ------------------------------
    // Widths that carry a meaning
    // ------------------------------
    typedef logic [31:0] haddr_t;     // Bus address
    typedef logic [31:0] hdata_t;     // Bus data word
    typedef logic [3:0]  hstrb_t;     // One bit per byte lane
    typedef logic [1:0]  reg_ofs_t;   // Word offset in a slave window
    typedef logic [7:0]  uart_byte_t; // Serial character

    // Transfer type codes of a real transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // Transfer size codes
    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // ------------------------------
    // Address map and registers
    // ------------------------------
    localparam haddr_t GPIO_BASE         = 32'h4000_0000;
    localparam haddr_t UART_BASE         = 32'h4000_0010;
    localparam int     SLAVE_WINDOW_BITS = 4;             // 16 bytes each

    localparam reg_ofs_t GPIO_OUT_OFS  = 2'd0;
    localparam reg_ofs_t GPIO_OE_OFS   = 2'd1;
    localparam reg_ofs_t GPIO_IN_OFS   = 2'd2;           // Read only
    localparam reg_ofs_t UART_DATA_OFS = 2'd0;
    localparam reg_ofs_t UART_STAT_OFS = 2'd1;

    localparam int STAT_TX_BUSY_BIT  = 0;
    localparam int STAT_RX_VALID_BIT = 1;

    // ------------------------------
    // Bus structs
    // ------------------------------
    typedef struct packed {
        haddr_t     haddr;
        logic [1:0] htrans;
        logic [2:0] hsize;
        logic       hwrite;
        hdata_t     hwdata;   // Belongs to the data phase
    } ahb_m2s_t;

    typedef struct packed {
        hdata_t hrdata;
        logic   hready;
        logic   hresp;        // Tied to OKAY
    } ahb_s2m_t;

    // Data-phase access handed to one slave
    typedef struct packed {
        logic     wr;
        logic     rd;
        reg_ofs_t ofs;
        hstrb_t   wstrb;
        hdata_t   wdata;
    } slv_access_t;

    // FSM states of the serial engines
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

// ==== logic/periph_soc.sv ====
// AHB-Lite peripheral subsystem with the bus master outside and pins without pads
`default_nettype none

module periph_soc
#(
    parameter int GPIO_WIDTH   = 32,
    parameter int CLKS_PER_BIT = 16
)
(
    input  wire logic                 clk,
    input  wire logic                 RSTn,
    input  wire periph_pkg::ahb_m2s_t i_bus,
    output periph_pkg::ahb_s2m_t      o_bus,
    input  wire logic [GPIO_WIDTH-1:0] i_gpio_in,
    output logic [GPIO_WIDTH-1:0]     o_gpio_out,
    output logic [GPIO_WIDTH-1:0]     o_gpio_oe,
    input  wire logic                 i_rxd,
    output logic                      o_txd,
    output logic                      o_irq
);
    import periph_pkg::*;

    // ------------------------------
    // Bus side
    // ------------------------------
    slv_access_t gpio_acc;
    slv_access_t uart_acc;
    hdata_t      gpio_rdata;
    hdata_t      uart_rdata;
    logic        uart_ready;   // Low while TX is back-pressured

    // Between UART registers and engines
    logic        tx_start;
    uart_byte_t  tx_byte;
    logic        tx_busy;
    logic        rx_strobe;
    uart_byte_t  rx_byte;

    ahb_decoder u_ahb_decoder
    (
        .clk          (clk),
        .RSTn         (RSTn),
        .i_bus        (i_bus),
        .o_bus        (o_bus),
        .o_gpio_acc   (gpio_acc),
        .o_uart_acc   (uart_acc),
        .i_gpio_rdata (gpio_rdata),
        .i_uart_rdata (uart_rdata),
        .i_uart_ready (uart_ready)
    );

    ahb_gpio #(.GPIO_WIDTH(GPIO_WIDTH)) u_ahb_gpio
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_acc      (gpio_acc),
        .o_rdata    (gpio_rdata),
        .i_gpio_in  (i_gpio_in),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe)
    );

    ahb_uart u_ahb_uart
    (
        .clk         (clk),
        .RSTn        (RSTn),
        .i_acc       (uart_acc),
        .o_rdata     (uart_rdata),
        .o_ready     (uart_ready),
        .o_tx_start  (tx_start),
        .o_tx_byte   (tx_byte),
        .i_tx_busy   (tx_busy),
        .i_rx_strobe (rx_strobe),
        .i_rx_byte   (rx_byte),
        .o_irq       (o_irq)
    );

    // ------------------------------
    // Serial engines
    // ------------------------------
    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx
    (
        .clk     (clk),
        .RSTn    (RSTn),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_busy  (tx_busy),
        .o_txd   (o_txd)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx
    (
        .clk      (clk),
        .RSTn     (RSTn),
        .i_rxd    (i_rxd),
        .o_strobe (rx_strobe),
        .o_byte   (rx_byte)
    );

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// 8N1 LSB first with CLKS_PER_BIT of 4 or more and framing errors dropped silently
`default_nettype none

module uart_rx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  wire logic              clk,
    input  wire logic              RSTn,
    input  wire logic              i_rxd,
    output logic                   o_strobe,
    output periph_pkg::uart_byte_t o_byte
);
    import periph_pkg::*;

    localparam int               CNT_W    = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       idx;
    uart_byte_t       shreg;    // Filled from the MSB end
    logic             rxd_s1;
    logic             rxd_s2;   // Synchronised line
    logic             bit_end;

    assign bit_end = cnt == BIT_END;

    // ------------------------------
    // Synchroniser and FSM
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            rxd_s1   <= 1'b1;
            rxd_s2   <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            idx      <= '0;
            o_strobe <= 1'b0;
        end
        else
        begin
            rxd_s1   <= i_rxd;
            rxd_s2   <= rxd_s1;
            o_strobe <= 1'b0;        // One cycle pulse
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE:
                begin
                    cnt <= '0;
                    if (!rxd_s2)         // Falling edge of the start bit
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (cnt == HALF_END)
                    begin
                        cnt   <= '0;
                        idx   <= '0;
                        state <= rxd_s2 ? RX_IDLE : RX_DATA; // Glitch check
                    end
                end
                RX_DATA:
                begin
                    if (bit_end)         // Middle of a data bit
                    begin
                        cnt <= '0;
                        idx <= idx + 1'b1;
                        if (idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP:
                begin
                    if (bit_end)
                    begin
                        cnt      <= '0;
                        state    <= RX_IDLE;
                        o_strobe <= rxd_s2;  // Low stop bit drops the byte
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && bit_end)
            shreg <= {rxd_s2, shreg[7:1]};
    end

    assign o_byte = shreg;

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// 8N1 LSB first with CLKS_PER_BIT of 4 or more and a frame that takes 10 bit times
`default_nettype none

module uart_tx
#(
    parameter int CLKS_PER_BIT = 16
)
(
    input  wire logic                   clk,
    input  wire logic                   RSTn,
    input  wire logic                   i_start,
    input  wire periph_pkg::uart_byte_t i_byte,
    output logic                        o_busy,
    output logic                        o_txd
);
    import periph_pkg::*;

    localparam int               CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;      // Clocks into the current bit
    logic [2:0]       idx;      // Data bit index
    uart_byte_t       shreg;    // Bits still to send, LSB next
    logic             bit_end;

    assign bit_end = cnt == BIT_END;
    assign o_busy  = state != TX_IDLE;

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            state <= TX_IDLE;
            cnt   <= '0;
            idx   <= '0;
            o_txd <= 1'b1;       // Line idles high
        end
        else
        begin
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE:
                begin
                    if (i_start)
                    begin
                        state <= TX_START;
                        o_txd <= 1'b0;   // Start bit
                    end
                end
                TX_START:
                begin
                    if (bit_end)
                    begin
                        state <= TX_DATA;
                        idx   <= '0;
                        o_txd <= shreg[0];
                    end
                end
                TX_DATA:
                begin
                    if (bit_end)
                    begin
                        if (idx == 3'd7)
                        begin
                            state <= TX_STOP;
                            o_txd <= 1'b1;    // Stop bit
                        end
                        else
                        begin
                            idx   <= idx + 1'b1;
                            o_txd <= shreg[1]; // Next one before the shift
                        end
                    end
                end
                TX_STOP:
                begin
                    if (bit_end)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift register
    always_ff @(posedge clk)
    begin
        if (state == TX_IDLE && i_start)
            shreg <= i_byte;
        else if (state == TX_DATA && bit_end)
            shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

// ==== periph_soc.f ====
logic/periph_pkg.sv
logic/ahb_decoder.sv
logic/ahb_gpio.sv
logic/ahb_uart.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/periph_soc.sv
verification/periph_soc_sva.sv
verification/tb_periph_soc.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; the exit status is the verdict
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --assert -j 0 \
    --top-module tb_periph_soc \
    -Mdir obj_dir \
    -f periph_soc.f &&
./obj_dir/Vtb_periph_soc ||
{
    echo "simulation did not complete cleanly" >&2
    exit 1
}

// ==== verification/periph_soc_sva.sv ====
// Bound into periph_soc and needs the internal uart_tx state and bus wires by name
`default_nettype none

module periph_soc_sva
(
    input  wire logic                    clk,
    input  wire logic                    RSTn,
    input  wire periph_pkg::tx_state_t   i_tx_state,
    input  wire periph_pkg::slv_access_t i_uart_acc,
    input  wire periph_pkg::ahb_s2m_t    i_bus_s2m,
    input  wire logic                    i_rx_strobe,
    input  wire logic                    i_txd,
    input  wire logic                    i_irq
);
    import periph_pkg::*;

    // ------------------------------
    // Serial line and interrupt
    // ------------------------------
    a_txd_idle_high: assert property (@(posedge clk) disable iff (!RSTn)
        i_tx_state == TX_IDLE |-> i_txd)
        else $error("o_txd is low while the transmitter is idle");

    // DATA read pops the byte unless a new one lands in the same cycle
    a_irq_clear: assert property (@(posedge clk) disable iff (!RSTn)
        (i_uart_acc.rd && i_uart_acc.ofs == UART_DATA_OFS && i_bus_s2m.hready
         && !i_rx_strobe) |=> !i_irq)
        else $error("o_irq still high after a DATA read");

    // Only a UART data phase may stall
    a_hready_uart_only: assert property (@(posedge clk) disable iff (!RSTn)
        !i_bus_s2m.hready |-> (i_uart_acc.wr || i_uart_acc.rd))
        else $error("hready low outside a UART data phase");

endmodule

bind periph_soc periph_soc_sva u_periph_soc_sva
(
    .clk         (clk),
    .RSTn        (RSTn),
    .i_tx_state  (u_uart_tx.state),
    .i_uart_acc  (uart_acc),
    .i_bus_s2m   (o_bus),
    .i_rx_strobe (rx_strobe),
    .i_txd       (o_txd),
    .i_irq       (o_irq)
);

`default_nettype wire

// ==== verification/tb_periph_soc.sv ====
// Single AHB master doing one transfer at a time, CLKS_PER_BIT fixed at 8 and 32 GPIO pins
`default_nettype none

module tb_periph_soc;
    import periph_pkg::*;

    localparam int          CLKS_PER_BIT = 8;
    localparam int          GPIO_WIDTH   = 32;
    localparam int          WAIT_LIMIT   = 40 * CLKS_PER_BIT; // Four frames in cycles
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;     // x^32+x^22+x^2+x+1

    logic                  clk;
    logic                  RSTn;
    ahb_m2s_t              bus_m2s;   // Master side
    ahb_s2m_t              bus_s2m;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_oe;
    logic                  rxd;
    logic                  txd;
    logic                  irq;

    logic [31:0] lfsr_q;        // Random source
    hdata_t      out_m;         // Model of the OUT register
    hdata_t      oe_m;          // Model of the OE register
    uart_byte_t  tx_exp_q[$];   // Bytes expected on o_txd

    periph_soc #(.GPIO_WIDTH(GPIO_WIDTH), .CLKS_PER_BIT(CLKS_PER_BIT)) u_periph_soc
    (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_bus      (bus_m2s),
        .o_bus      (bus_s2m),
        .i_gpio_in  (gpio_in),
        .o_gpio_out (gpio_out),
        .o_gpio_oe  (gpio_oe),
        .i_rxd      (rxd),
        .o_txd      (txd),
        .o_irq      (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Error reporting
    // ------------------------------
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        logic        b;
        res = '0;
        for (int i = 0; i < n; i++)
        begin
            b      = lfsr_q[0];
            lfsr_q = (lfsr_q >> 1) ^ (b ? LFSR_TAPS : 32'h0);
            res    = {res[30:0], b};
        end
        return res;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic hstrb_t lanes_for(input logic [2:0] size, input logic [1:0] lo);
        hstrb_t res;
        for (int k = 0; k < 4; k++)
        begin
            if (size == HSIZE_BYTE)
                res[k] = (k == int'(lo));
            else if (size == HSIZE_HALF)
                res[k] = (k / 2 == int'(lo[1]));   // Lower or upper half
            else
                res[k] = 1'b1;
        end
        return res;
    endfunction

    function automatic hdata_t merge_bytes(input hdata_t old, input hdata_t data,
                                           input hstrb_t strb);
        hdata_t res;
        res = old;
        for (int k = 0; k < 4; k++)
        begin
            if (strb[k])
                res[8*k +: 8] = data[8*k +: 8];
        end
        return res;
    endfunction

    // ------------------------------
    // AHB master
    // ------------------------------
    task automatic bus_transfer(input haddr_t addr, input logic [2:0] size, input logic write,
                                input hdata_t wdata, output hdata_t rdata, output int stalls);
        @(negedge clk);
        bus_m2s.haddr  = addr;
        bus_m2s.htrans = HTRANS_NONSEQ;
        bus_m2s.hsize  = size;
        bus_m2s.hwrite = write;
        @(negedge clk);                 // Address phase taken at the edge in between
        bus_m2s.htrans = 2'b00;         // IDLE after a single transfer
        bus_m2s.hwdata = write ? wdata : '0;
        stalls = 0;
        #1;                             // Let the bus outputs settle
        while (!bus_s2m.hready)
        begin
            stalls++;
            if (stalls > WAIT_LIMIT)
                report_error("hready stayed low past the wait limit");
            @(negedge clk);
            #1;
        end
        check_eq("hresp", 32'(bus_s2m.hresp), 32'h0);
        rdata = bus_s2m.hrdata;
        @(posedge clk);                 // End of the data phase
    endtask

    task automatic bus_write(input haddr_t addr, input logic [2:0] size, input hdata_t data);
        hdata_t rd_unused;
        int     stalls;
        bus_transfer(addr, size, 1'b1, data, rd_unused, stalls);
        check_eq("write wait states", 32'(stalls), 32'h0);
    endtask

    task automatic check_read(input string name, input haddr_t addr, input hdata_t exp);
        hdata_t got;
        int     stalls;
        bus_transfer(addr, HSIZE_WORD, 1'b0, '0, got, stalls);
        check_eq(name, got, exp);
        check_eq("read wait states", 32'(stalls), 32'h0);
    endtask

    task automatic check_gpio_state();
        @(negedge clk);
        check_eq("o_gpio_out", gpio_out, out_m);
        check_eq("o_gpio_oe", gpio_oe, oe_m);
        check_read("OUT read", GPIO_BASE | haddr_t'({GPIO_OUT_OFS, 2'b00}), out_m);
        check_read("OE read", GPIO_BASE | haddr_t'({GPIO_OE_OFS, 2'b00}), oe_m);
    endtask

    // ------------------------------
    // UART line model
    // ------------------------------
    task automatic send_serial(input uart_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};     // Stop, data LSB first, start
        for (int b = 0; b < 10; b++)
        begin
            @(negedge clk);
            rxd = frame[b];
            repeat (CLKS_PER_BIT - 1) @(negedge clk);
        end
    endtask

    task automatic capture_frame(output uart_byte_t data);
        int n;
        n = 0;
        @(negedge clk);
        while (txd)
        begin
            n++;
            if (n > WAIT_LIMIT)
                report_error("no start bit appeared on o_txd");
            @(negedge clk);
        end
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);  // Near the start bit centre
        check_eq("o_txd start bit", 32'(txd), 32'h0);
        for (int b = 0; b < 8; b++)
        begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[b] = txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_eq("o_txd stop bit", 32'(txd), 32'h1);
    endtask

    // ------------------------------
    // Behaviors
    // ------------------------------
    task automatic check_reset_values();
        check_eq("o_txd", 32'(txd), 32'h1);
        check_eq("o_irq", 32'(irq), 32'h0);
        check_eq("hready", 32'(bus_s2m.hready), 32'h1);
        check_eq("o_gpio_oe", gpio_oe, '0);
        check_eq("o_gpio_out", gpio_out, '0);
        check_read("OUT read", GPIO_BASE | haddr_t'({GPIO_OUT_OFS, 2'b00}), '0);
        check_read("OE read", GPIO_BASE | haddr_t'({GPIO_OE_OFS, 2'b00}), '0);
        check_read("STAT read", UART_BASE | haddr_t'({UART_STAT_OFS, 2'b00}), '0);
    endtask

    task automatic check_gpio_writes();
        logic       sel;
        logic [1:0] r;
        logic [2:0] size;
        logic [1:0] lo;
        hdata_t     data;
        hstrb_t     strb;
        for (int n = 0; n < 24; n++)
        begin
            sel  = 1'(rand_bits(1));
            r    = 2'(rand_bits(2));
            size = r[1] ? HSIZE_WORD : (r[0] ? HSIZE_HALF : HSIZE_BYTE);
            if (size == HSIZE_BYTE)
                lo = 2'(rand_bits(2));
            else if (size == HSIZE_HALF)
                lo = {1'(rand_bits(1)), 1'b0};
            else
                lo = 2'b00;
            data = rand_bits(32);
            strb = lanes_for(size, lo);
            if (sel)
                oe_m = merge_bytes(oe_m, data, strb);
            else
                out_m = merge_bytes(out_m, data, strb);
            bus_write(GPIO_BASE | haddr_t'({sel ? GPIO_OE_OFS : GPIO_OUT_OFS, lo}), size, data);
            check_gpio_state();
        end
    endtask

    task automatic check_gpio_input();
        hdata_t v;
        for (int n = 0; n < 4; n++)
        begin
            v = rand_bits(32);
            @(negedge clk);
            gpio_in = v;
            repeat (3) @(negedge clk);  // Through the synchroniser
            check_read("IN read", GPIO_BASE | haddr_t'({GPIO_IN_OFS, 2'b00}), v);
        end
    endtask

    task automatic check_transmit();
        uart_byte_t b0;
        uart_byte_t b1;
        uart_byte_t got;
        uart_byte_t exp_b;
        hdata_t     rd_unused;
        int         stalls;
        b0 = uart_byte_t'(rand_bits(8));
        b1 = uart_byte_t'(rand_bits(8));
        tx_exp_q.push_back(b0);
        tx_exp_q.push_back(b1);
        fork
            begin
                bus_transfer(UART_BASE, HSIZE_BYTE, 1'b1, hdata_t'(b0), rd_unused, stalls);
                bus_transfer(UART_BASE, HSIZE_BYTE, 1'b1, hdata_t'(b1), rd_unused, stalls);
                assert (stalls > 0)
                    else report_error("second TXDATA write did not stall while busy");
            end
            begin
                for (int f = 0; f < 2; f++)
                begin
                    capture_frame(got);
                    exp_b = tx_exp_q.pop_front();
                    check_eq("o_txd byte", 32'(got), 32'(exp_b));
                end
            end
        join
    endtask

    task automatic check_receive();
        uart_byte_t b;
        hdata_t     stat_exp;
        int         n;
        stat_exp                    = '0;
        stat_exp[STAT_RX_VALID_BIT] = 1'b1;   // Transmitter idle by now
        for (int k = 0; k < 4; k++)
        begin
            b = uart_byte_t'(rand_bits(8));
            send_serial(b);
            n = 0;
            while (!irq)
            begin
                n++;
                if (n > WAIT_LIMIT)
                    report_error("o_irq never rose after a received byte");
                @(negedge clk);
            end
            check_read("STAT read", UART_BASE | haddr_t'({UART_STAT_OFS, 2'b00}), stat_exp);
            check_read("DATA read", UART_BASE | haddr_t'({UART_DATA_OFS, 2'b00}), hdata_t'(b));
            @(negedge clk);
            check_eq("o_irq", 32'(irq), 32'h0);
        end
    endtask

    task automatic check_unmapped();
        int     ofs_i;
        haddr_t addr;
        for (int n = 0; n < 4; n++)
        begin
            ofs_i = 32 + int'(rand_bits(8)) % 224;   // 0x20 to 0xFF
            addr  = 32'h4000_0000 + haddr_t'(ofs_i & ~3);
            bus_write(addr, HSIZE_WORD, rand_bits(32));
            check_read("unmapped read", addr, '0);
            check_gpio_state();                      // GPIO untouched
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial
    begin
        lfsr_q  = 32'h70de_a455;
        RSTn    = 1'b0;
        bus_m2s = '0;
        gpio_in = '0;
        rxd     = 1'b1;   // Line idles high
        out_m   = '0;
        oe_m    = '0;
        repeat (10) @(negedge clk);
        RSTn = 1'b1;
        check_reset_values();
        check_gpio_writes();
        check_gpio_input();
        check_transmit();
        check_receive();
        check_unmapped();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
